//--- bench/data_collect_chk.sv
`include "data_buffer_config.svh"

module data_collect_chk import data_buffer_pkg::*; (
    input  logic                        clkbuffer,
    input  logic                        arst_n,
    input  buf_state_e                  state,
    input  logic                        busy,
    input  logic                        ram_wen,
    input  logic [`BUF_RAM_AWIDTH-1:0]  ram_waddr
);

    timeunit 1ns;
    timeprecision 1ps;

    // ------------------------------------------------------------------------
    // write port only active while a frame is being stored
    // ------------------------------------------------------------------------
    wen_in_frame: assert property (@(posedge clkbuffer) disable iff (!arst_n)
        ram_wen |-> (state == st_time_stamp || state == st_loop_main))
        else $error("RAM write enable high outside time_stamp and loop_main");

    idle_not_busy: assert property (@(posedge clkbuffer) disable iff (!arst_n)
        state == st_idle |-> !busy)
        else $error("busy set while the FSM is idle");

    // back to back writes fill consecutive words
    waddr_step: assert property (@(posedge clkbuffer) disable iff (!arst_n)
        (ram_wen && $past(ram_wen)) |-> ram_waddr == $past(ram_waddr) + 1'b1)
        else $error("RAM write address skipped within a frame");

    state_legal: assert property (@(posedge clkbuffer) disable iff (!arst_n)
        state inside {st_idle, st_wait_config, st_mode_sample,
                      st_mode_continuous, st_time_stamp, st_loop_main})
        else $error("FSM state outside its enum values");

endmodule

//--- bench/data_collect_tb.sv
module data_collect_tb import data_buffer_pkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    localparam string VEC_FILE = "bench/data_collect_vectors.txt";

    logic           clkbuffer = 1'b0;
    logic           arst_n;
    logic [31:0]    ts;
    logic           data_fb_wen;
    sensor_frame_t  sensors;
    reg_wr_t        reg_wr;
    logic [15:0]    reg_raddr;
    logic [31:0]    reg_rdata;
    buf_status_t    buf_status;

    logic [7:0]     op_q [$];       // one entry per vector line
    logic [15:0]    addr_q [$];
    logic [31:0]    data_q [$];
    int             errors = 0;
    int             checks = 0;
    int             cycles = 0;
    int             cycle_limit = 0;    // 0 until the vectors are loaded

    always #50 clkbuffer = ~clkbuffer;  // 100 ns period

    data_collect_top dut (
        .clkbuffer   (clkbuffer),
        .arst_n      (arst_n),
        .ts          (ts),
        .data_fb_wen (data_fb_wen),
        .sensors     (sensors),
        .reg_wr      (reg_wr),
        .reg_raddr   (reg_raddr),
        .reg_rdata   (reg_rdata),
        .buf_status  (buf_status)
    );

    bind data_buffer data_collect_chk u_chk (
        .clkbuffer (clkbuffer),
        .arst_n    (arst_n),
        .state     (state),
        .busy      (busy),
        .ram_wen   (ram_wen),
        .ram_waddr (ram_waddr)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // bus and sensor operations
    // ------------------------------------------------------------------------
    task automatic reg_write(input logic [15:0] addr, input logic [31:0] data);
        @(posedge clkbuffer);
        reg_wr <= '{wen: 1'b1, waddr: addr, wdata: data};
        @(posedge clkbuffer);           // write taken on this edge
        reg_wr.wen <= 1'b0;
    endtask

    // sensors from a base value: pot base+i, cur base+8+i, enc {base+i, base}
    task automatic strobe_frame(input logic [15:0] base, input logic [31:0] stamp);
        sensor_frame_t f;
        for (int i = 0; i < 4; i++) begin
            f.pot[i] = base + 16'(i);
            f.cur[i] = base + 16'(i + 8);
            f.enc[i] = {base + 16'(i), base};
        end
        @(posedge clkbuffer);
        sensors     <= f;
        ts          <= stamp;
        data_fb_wen <= 1'b1;
        @(posedge clkbuffer);
        data_fb_wen <= 1'b0;            // one cycle pulse
        repeat (16) @(posedge clkbuffer);
    endtask

    // registered read, result one cycle after the address
    task automatic reg_read(input logic [15:0] addr, input logic [31:0] exp);
        string name;
        @(posedge clkbuffer);
        reg_raddr <= addr;
        @(posedge clkbuffer);
        @(negedge clkbuffer);           // mid-cycle, rdata settled
        name = $sformatf("reg_rdata[%04h]", addr);
        check_value(name, reg_rdata, exp);
        if (addr[11:0] == 12'h800) begin
            // status port carries the low half of the status word
            check_value("buf_status", {16'd0, buf_status}, {16'd0, exp[15:0]});
        end
    endtask

    always @(posedge clkbuffer) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: vectors not finished after %0d cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // load vectors, reset, run
    // ------------------------------------------------------------------------
    initial begin
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [15:0] addr;
        logic [31:0] data;
        arst_n      = 1'b0;
        ts          = '0;
        data_fb_wen = 1'b0;
        sensors     = '0;
        reg_wr      = '0;
        reg_raddr   = '0;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("cannot open vector file %s", VEC_FILE);
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %h %h", op, addr, data);
                if (n == 3) begin       // comment and blank lines fall out here
                    op_q.push_back(op);
                    addr_q.push_back(addr);
                    data_q.push_back(data);
                end
            end
            $fclose(fd);
        end
        cycle_limit = op_q.size() * 40 + 200;
        repeat (16) @(posedge clkbuffer);
        arst_n <= 1'b1;
        @(posedge clkbuffer);
        foreach (op_q[i]) begin
            case (op_q[i])
                "W":     reg_write(addr_q[i], data_q[i]);
                "S":     strobe_frame(addr_q[i], data_q[i]);
                "R":     reg_read(addr_q[i], data_q[i]);
                default: begin
                    $display("unknown operation in vector %0d", i);
                    errors++;
                end
            endcase
        end
        @(posedge clkbuffer);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- bench/data_collect_vectors.txt
// op addr data, hex. W writes data to addr, R reads addr and expects data
// S strobes one frame with sensor base in addr and ts in data
W 7100 00000002  sample mode, two frames
W 7010 00000000  start
W 7001 00000003  three signals
W 7101 00000011  pot ch1 16 bit
W 7101 00001001  cur ch0 16 bit
W 7101 00002003  enc ch0 32 bit
S 1234 00001234  ts below 2^14
S 4321 0001C005  ts above 2^14
R 7000 00009234
R 7001 00001235
R 7002 0000123C
R 7003 12341234
R 7004 0000C005
R 7005 00004322
R 7006 00004329
R 7007 43214321
R 7800 00070C08  done, busy low, aligned address 8
W 7200 00000000  continuous mode
W 7001 00000003  new layout from idle
W 7101 00002000  enc ch0 8 bit
W 7101 00002001  enc ch0 16 bit
W 7101 00002003  enc ch0 32 bit
W 7010 00000000  start
S A5A5 00004000
W 7001 00000005  ignored while busy
R 7800 00078C04
S 0F0F 00003FFF
W 7020 00000000  stop
S 5555 00000001  lost, machine idle
R 7800 00070C08
R 7000 0000C000
R 7001 000000A5
R 7002 0000A5A5
R 7003 A5A5A5A5
R 7004 0000BFFF
R 7005 0000000F
R 7006 00000F0F
R 7007 0F0F0F0F

//--- list.f
+incdir+source
source/data_buffer_pkg.sv
source/buffer_ram.sv
source/signal_select.sv
source/data_buffer.sv
source/data_collect_top.sv
bench/data_collect_chk.sv
bench/data_collect_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the data collection testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    -f list.f --top-module data_collect_tb -o data_collect_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/data_collect_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi
exit 1

//--- source/buffer_ram.sv
`include "data_buffer_config.svh"

module buffer_ram (
    input  logic                        clkbuffer,
    input  logic                        wen,
    input  logic [`BUF_RAM_AWIDTH-1:0]  waddr,
    input  logic [31:0]                 wdata,
    input  logic [`BUF_RAM_AWIDTH-1:0]  raddr,
    output logic [31:0]                 rdata
);

    logic [31:0] mem [`BUF_RAM_DEPTH];

    // write port, one word per cycle
    always_ff @(posedge clkbuffer) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // read port, data one cycle after the address
    always_ff @(posedge clkbuffer) begin
        rdata <= mem[raddr];
    end

endmodule

//--- source/data_buffer.sv
`include "data_buffer_config.svh"

module data_buffer import data_buffer_pkg::*; (
    input  logic           clkbuffer,
    input  logic           arst_n,
    input  logic [31:0]    ts,
    input  logic           data_fb_wen,    // async data-valid strobe
    input  logic [31:0]    sample_data,    // selected value for cur_spec
    input  reg_wr_t        reg_wr,
    input  logic [15:0]    reg_raddr,
    output signal_spec_t   cur_spec,
    output logic [31:0]    reg_rdata,
    output buf_status_t    buf_status
);

    localparam int AW = `BUF_RAM_AWIDTH;

    logic                     page_wen;
    logic                     struct_wen;     // any layout write
    logic                     stat_wen;       // any command write
    logic                     num_wen;
    logic                     spec_wen;
    logic                     mode_wen;
    collect_mode_e            wr_mode;
    collect_cmd_e             wr_cmd;
    logic [3:0]               sig_num;
    logic [3:0]               spec_idx;
    logic                     layout_done;
    signal_spec_t             specs [`BUF_MAX_SIGNALS];
    collect_mode_e            collect_mode;
    logic [`BUF_FRAME_W-1:0]  frame_req;
    logic [`BUF_FRAME_W-1:0]  frame_cnt;
    logic                     start_flag;
    logic                     sample_done;
    logic [2:0]               fb_sync;        // 2 sync flops + edge flop
    logic                     fb_trigger;
    buf_state_e               state;
    logic                     busy;
    logic [3:0]               sig_idx;
    logic                     ram_wen;
    logic [AW-1:0]            ram_waddr;
    logic [AW-1:0]            waddr_align;
    logic [31:0]              ram_wdata;
    logic [31:0]              ram_rdata;
    logic [31:0]              ts_word;
    logic                     host_ram_read;
    logic [AW-1:0]            last_raddr;
    logic                     rd_ram_q;
    logic [31:0]              rd_word_q;

    // mode opcode -> armed state, idle if no valid mode
    function automatic buf_state_e mode_state(collect_mode_e m);
        case (m)
            mode_sample:     return st_mode_sample;
            mode_continuous: return st_mode_continuous;
            default:         return st_idle;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // register write decode
    // ------------------------------------------------------------------------
    assign page_wen   = reg_wr.wen && reg_wr.waddr[`BUF_FIELD_PAGE] == `BUF_ADDR_PAGE;
    assign struct_wen = page_wen && reg_wr.waddr[`BUF_FIELD_OFF] == `BUF_OFF_STRUCT;
    assign stat_wen   = page_wen && reg_wr.waddr[`BUF_FIELD_OFF] == `BUF_OFF_STAT;
    assign num_wen    = struct_wen && !busy && reg_wr.waddr[`BUF_FIELD_SEL] == `BUF_SEL_NUM;
    assign spec_wen   = struct_wen && !busy && reg_wr.waddr[`BUF_FIELD_SEL] == `BUF_SEL_SPEC;
    assign wr_mode    = collect_mode_e'(reg_wr.waddr[`BUF_FIELD_SEL]);
    assign wr_cmd     = collect_cmd_e'(reg_wr.waddr[`BUF_FIELD_CMD]);
    assign mode_wen   = stat_wen && !busy &&
                        (wr_mode == mode_sample || wr_mode == mode_continuous);

    // frame layout, count write restarts the spec index
    always_ff @(posedge clkbuffer or negedge arst_n) begin
        if (!arst_n) begin
            sig_num  <= '0;
            spec_idx <= '0;
        end else if (num_wen) begin
            sig_num  <= reg_wr.wdata[`BUF_NUM_FIELD];
            spec_idx <= '0;
        end else if (spec_wen) begin
            spec_idx <= spec_idx + 4'd1;
        end
    end

    always_ff @(posedge clkbuffer) begin
        if (spec_wen) begin
            specs[spec_idx] <= '{src_type: reg_wr.wdata[`BUF_SPEC_TYPE],
                                 channel:  reg_wr.wdata[`BUF_SPEC_CHAN],
                                 format:   reg_wr.wdata[`BUF_SPEC_FMT]};
        end
    end

    assign layout_done = (sig_num != 4'd0) && (spec_idx == sig_num);
    assign cur_spec    = specs[sig_idx];    // to the selector

    // mode and requested frames, frozen while busy
    always_ff @(posedge clkbuffer or negedge arst_n) begin
        if (!arst_n) begin
            collect_mode <= mode_sample;
            frame_req    <= '0;
        end else if (mode_wen) begin
            collect_mode <= wr_mode;
            frame_req    <= (wr_mode == mode_sample) ? reg_wr.wdata[`BUF_FRAME_W-1:0] : '0;
        end
    end

    // start/stop accepted any time, sample mode clears it when done
    assign sample_done = (state == st_mode_sample) && start_flag && (frame_cnt == frame_req);

    always_ff @(posedge clkbuffer or negedge arst_n) begin
        if (!arst_n) begin
            start_flag <= 1'b0;
        end else if (stat_wen && wr_cmd == cmd_start) begin
            start_flag <= 1'b1;
        end else if ((stat_wen && wr_cmd == cmd_stop) || sample_done) begin
            start_flag <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // strobe synchronizer and edge detect
    // ------------------------------------------------------------------------
    always_ff @(posedge clkbuffer or negedge arst_n) begin
        if (!arst_n) begin
            fb_sync <= '0;
        end else begin
            fb_sync <= {fb_sync[1:0], data_fb_wen};
        end
    end

    assign fb_trigger = fb_sync[1] && !fb_sync[2];  // rise of the 2nd flop

    // ------------------------------------------------------------------------
    // collection FSM
    // ------------------------------------------------------------------------
    assign ts_word = {16'd0, 1'b1, |ts[31:`BUF_TS_LOW_BITS], ts[`BUF_TS_LOW_BITS-1:0]};

    // write port straight from the state, no extra cycle
    assign ram_wen   = (state == st_time_stamp) ||
                       (state == st_loop_main && sig_idx != sig_num);
    assign ram_wdata = (state == st_time_stamp) ? ts_word : sample_data;

    always_ff @(posedge clkbuffer or negedge arst_n) begin
        if (!arst_n) begin
            state       <= st_wait_config;
            busy        <= 1'b0;
            sig_idx     <= '0;
            ram_waddr   <= '0;
            waddr_align <= '0;
            frame_cnt   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (struct_wen) begin
                        state <= st_wait_config;    // new layout on its way
                    end else if (start_flag) begin
                        busy      <= 1'b1;          // resume with old layout
                        frame_cnt <= '0;
                        state     <= mode_state(collect_mode);
                    end
                end
                st_wait_config: begin
                    if (layout_done) begin
                        busy      <= 1'b1;
                        ram_waddr <= '0;
                        frame_cnt <= '0;
                        state     <= mode_state(collect_mode);
                    end
                end
                st_mode_sample, st_mode_continuous: begin
                    if (!start_flag || sample_done) begin
                        busy  <= 1'b0;              // stopped or enough frames
                        state <= st_idle;
                    end else if (fb_trigger) begin
                        sig_idx <= '0;
                        state   <= st_time_stamp;
                    end
                end
                st_time_stamp: begin
                    ram_waddr <= ram_waddr + 1'b1;
                    frame_cnt <= frame_cnt + 1'b1;
                    state     <= st_loop_main;
                end
                st_loop_main: begin
                    if (sig_idx == sig_num) begin
                        waddr_align <= ram_waddr;   // frame complete
                        state       <= mode_state(collect_mode);
                    end else begin
                        ram_waddr <= ram_waddr + 1'b1;
                        sig_idx   <= sig_idx + 4'd1;
                    end
                end
                default: begin
                    busy  <= 1'b0;
                    state <= st_idle;
                end
            endcase
        end
    end

    assign buf_status = '{busy: busy, zero: 1'b0, sig_num: sig_num, waddr_align: waddr_align};

    // ------------------------------------------------------------------------
    // host read path
    // ------------------------------------------------------------------------
    assign host_ram_read = !reg_raddr[11];

    always_ff @(posedge clkbuffer or negedge arst_n) begin
        if (!arst_n) begin
            last_raddr <= '0;
        end else if (host_ram_read) begin
            last_raddr <= reg_raddr[AW-1:0];
        end
    end

    // select registered alongside the RAM read
    always_ff @(posedge clkbuffer) begin
        rd_ram_q  <= host_ram_read;
        rd_word_q <= (reg_raddr[11:0] == `BUF_STATUS_ADDR) ?
                     {{(16-AW){1'b0}}, last_raddr, buf_status} : 32'd0;
    end

    assign reg_rdata = rd_ram_q ? ram_rdata : rd_word_q;

    buffer_ram u_ram (
        .clkbuffer (clkbuffer),
        .wen       (ram_wen),
        .waddr     (ram_waddr),
        .wdata     (ram_wdata),
        .raddr     (reg_raddr[AW-1:0]),
        .rdata     (ram_rdata)
    );

endmodule

//--- source/data_buffer_config.svh
`ifndef DATA_BUFFER_CONFIG_SVH
`define DATA_BUFFER_CONFIG_SVH

// ---------------------------------------------------------------------------
// register map of the buffer page
// ---------------------------------------------------------------------------
`define BUF_ADDR_PAGE      4'h7        // address [15:12] of the buffer page
`define BUF_OFF_STAT       4'h0        // [3:0] offset, mode and start/stop writes
`define BUF_OFF_STRUCT     4'h1        // [3:0] offset, layout writes
`define BUF_SEL_NUM        4'h0        // [11:8] of a layout write, signal count
`define BUF_SEL_SPEC       4'h1        // [11:8] of a layout write, one signal spec
`define BUF_STATUS_ADDR    12'h800     // read offset of the status word

// address and data field positions
`define BUF_FIELD_PAGE     15:12
`define BUF_FIELD_SEL      11:8        // layout selector or mode opcode
`define BUF_FIELD_CMD      7:4         // start/stop opcode
`define BUF_FIELD_OFF      3:0
`define BUF_SPEC_TYPE      15:12       // spec write data, source type
`define BUF_SPEC_CHAN      7:4         // spec write data, channel
`define BUF_SPEC_FMT       3:0         // spec write data, format
`define BUF_NUM_FIELD      3:0         // count write data
`define BUF_FRAME_W        11          // requested frame count width

// ---------------------------------------------------------------------------
// RAM and frame geometry
// ---------------------------------------------------------------------------
`define BUF_RAM_AWIDTH     10
`define BUF_RAM_DEPTH      (1 << `BUF_RAM_AWIDTH)
`define BUF_MAX_SIGNALS    16
`define BUF_TS_LOW_BITS    14          // timestamp bits kept in the ts word

// source types and bit formats
`define BUF_SRC_POT        4'd0
`define BUF_SRC_CUR        4'd1
`define BUF_SRC_ENC        4'd2
`define BUF_FMT_8          4'd0
`define BUF_FMT_16         4'd1
`define BUF_FMT_24         4'd2

`endif

//--- source/data_buffer_pkg.sv
`include "data_buffer_config.svh"

package data_buffer_pkg;

    // collection FSM
    typedef enum logic [2:0] {
        st_idle,                // waiting for start or a new layout
        st_wait_config,         // layout being written
        st_mode_sample,         // armed, stops after frame_req frames
        st_mode_continuous,     // armed until stop
        st_time_stamp,          // writes the ts word
        st_loop_main            // writes the signal words
    } buf_state_e;

    // opcode in waddr[11:8] of a command write
    typedef enum logic [3:0] {
        mode_sample     = 4'd1,
        mode_continuous = 4'd2
    } collect_mode_e;

    // opcode in waddr[7:4] of a command write
    typedef enum logic [3:0] {
        cmd_start = 4'd1,
        cmd_stop  = 4'd2
    } collect_cmd_e;

    typedef struct packed {
        logic [3:0] src_type;   // pot, cur or enc
        logic [3:0] channel;
        logic [3:0] format;     // 8*(f+1) bits kept
    } signal_spec_t;

    typedef struct packed {
        logic [3:0][15:0] pot;
        logic [3:0][15:0] cur;
        logic [3:0][31:0] enc;
    } sensor_frame_t;

    typedef struct packed {
        logic        wen;
        logic [15:0] waddr;
        logic [31:0] wdata;
    } reg_wr_t;

    typedef struct packed {
        logic                        busy;
        logic                        zero;        // always 0
        logic [3:0]                  sig_num;
        logic [`BUF_RAM_AWIDTH-1:0]  waddr_align; // next free frame address
    } buf_status_t;

endpackage

//--- source/data_collect_top.sv
module data_collect_top import data_buffer_pkg::*; (
    input  logic           clkbuffer,
    input  logic           arst_n,
    input  logic [31:0]    ts,
    input  logic           data_fb_wen,
    input  sensor_frame_t  sensors,
    input  reg_wr_t        reg_wr,
    input  logic [15:0]    reg_raddr,
    output logic [31:0]    reg_rdata,
    output buf_status_t    buf_status
);

    signal_spec_t cur_spec;         // spec of the signal being written
    logic [31:0]  sample_data;      // masked value back to the buffer

    // ------------------------------------------------------------------------
    // buffer with RAM, FSM and register port
    // ------------------------------------------------------------------------
    data_buffer u_buffer (
        .clkbuffer   (clkbuffer),
        .arst_n      (arst_n),
        .ts          (ts),
        .data_fb_wen (data_fb_wen),
        .sample_data (sample_data),
        .reg_wr      (reg_wr),
        .reg_raddr   (reg_raddr),
        .cur_spec    (cur_spec),
        .reg_rdata   (reg_rdata),
        .buf_status  (buf_status)
    );

    // combinational pick from the sensor frame
    signal_select u_select (
        .sensors     (sensors),
        .spec        (cur_spec),
        .sample_data (sample_data)
    );

endmodule

//--- source/signal_select.sv
`include "data_buffer_config.svh"

module signal_select import data_buffer_pkg::*; (
    input  sensor_frame_t  sensors,
    input  signal_spec_t   spec,
    output logic [31:0]    sample_data
);

    logic [1:0]  chan;      // four channels per sensor group
    logic [31:0] raw;       // zero-extended sensor value
    logic [31:0] mask;

    assign chan = spec.channel[1:0];

    // ------------------------------------------------------------------------
    // source group and channel
    // ------------------------------------------------------------------------
    always_comb begin
        case (spec.src_type)
            `BUF_SRC_POT: raw = {16'd0, sensors.pot[chan]};
            `BUF_SRC_CUR: raw = {16'd0, sensors.cur[chan]};
            `BUF_SRC_ENC: raw = sensors.enc[chan];
            default:      raw = 32'd0;      // unknown source reads zero
        endcase
    end

    // ------------------------------------------------------------------------
    // format width
    // ------------------------------------------------------------------------
    always_comb begin
        case (spec.format)
            `BUF_FMT_8:  mask = 32'h0000_00ff;
            `BUF_FMT_16: mask = 32'h0000_ffff;
            `BUF_FMT_24: mask = 32'h00ff_ffff;
            default:     mask = 32'hffff_ffff;  // 3 and up, full word
        endcase
    end

    assign sample_data = raw & mask;

endmodule
